/* Makefile */
VERILATOR   ?= verilator
TOP         ?= mmio_tb
FILELIST    ?= sources.f
OBJ_DIR     ?= obj_dir
MEM_BYTES   ?= 2048
WAIT_STATES ?= 2
SCLK_DIV    ?= 2
VFLAGS      ?= --binary --timing --assert
PASS_MSG    ?= RESULT: PASS

BIN := $(OBJ_DIR)/V$(TOP)
GFLAGS := -GMEM_BYTES=$(MEM_BYTES) -GWAIT_STATES=$(WAIT_STATES) -GSCLK_DIV=$(SCLK_DIV)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) $(GFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# output goes to the terminal and is searched for the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/mmio_tb.sv */
`timescale 1ns/1ns

module mmio_tb import mmio_pkg::*; #(
    parameter int MEM_BYTES   = 2048,
    parameter int WAIT_STATES = 2,
    parameter int SCLK_DIV    = 2
) ();

    localparam int CLK_PERIOD = 20;
    localparam int AW         = $clog2(MEM_BYTES / 4);
    localparam int TOUCH_HOLD = 6;      // cycles the touch read is left stalled
    // worst entry is a param write stalled behind a full 5 byte transfer
    localparam int ENTRY_CYCLES = WAIT_STATES + TOUCH_HOLD + 16 + 2 * SCLK_DIV * 42;

    typedef struct packed {
        logic              rd;
        logic              touch_late;  // i2c_done_i low at issue
        logic              wait_cs;     // must stall behind a running transfer
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] wdata;       // touch coordinate for i2c reads
        logic [DATA_W-1:0] exp;
    } entry_t;

    logic              clk, nRst, read_i, write_i, busy_o, done_o, i2c_done_i;
    logic [DATA_W-1:0] address_i, wdata_i, rdata_o, i2c_xy_i;
    logic              spi_sclk_o, spi_mosi_o, spi_cs_n_o, spi_dc_o;

    entry_t            tbl[$];
    logic [DATA_W-1:0] shadow [MEM_BYTES/4];   // expected ram contents
    logic [1:0]        exp_bits[$];            // {dc, mosi} in send order
    logic [1:0]        spi_exp;
    logic [7:0]        cur_cmd;
    int                cur_count, n_transfers, cs_rises, cs_base;
    int                val_errs, spi_errs, proto_errs;
    logic              table_ready;

    mmio_subsystem #(
        .MEM_BYTES(MEM_BYTES), .WAIT_STATES(WAIT_STATES), .SCLK_DIV(SCLK_DIV)
    ) mmio_subsystem_i (
        .clk, .nRst, .read_i, .write_i, .address_i, .wdata_i, .rdata_o, .busy_o, .done_o,
        .i2c_xy_i, .i2c_done_i, .spi_sclk_o, .spi_mosi_o, .spi_cs_n_o, .spi_dc_o
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // mode 0 so sample on rising sclk
    always @(posedge spi_sclk_o) begin
        if (exp_bits.size() == 0) begin
            spi_errs++;
            $display("%0t ns: SPI clock edge while no transfer was expected", $time);
        end else begin
            spi_exp = exp_bits.pop_front();
            if ({spi_dc_o, spi_mosi_o} !== spi_exp) begin
                spi_errs++;
                $display("ERROR t=%0t spi_dc_o,spi_mosi_o: got %b expected %b",
                         $time, {spi_dc_o, spi_mosi_o}, spi_exp);
            end
        end
    end

    always @(posedge spi_cs_n_o) cs_rises++;    // one per finished transfer

    task automatic check_val(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            val_errs++;
            $display("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        proto_errs++;
        $display("%0t ns: %s", $time, msg);
    endtask

    task automatic push_entry(input logic rd, input logic [DATA_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata, input logic [DATA_W-1:0] exp,
                              input logic late, input logic wait_cs);
        entry_t e;
        e.rd = rd;
        e.touch_late = late;
        e.wait_cs = wait_cs;
        e.addr = addr;
        e.wdata = wdata;
        e.exp = exp;
        tbl.push_back(e);
    endtask

    task automatic add_write(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
        if (addr < DATA_W'(MEM_BYTES)) shadow[addr[AW+1:2]] = data;
        push_entry(1'b0, addr, data, '0, 1'b0, 1'b0);
    endtask

    task automatic add_read(input logic [DATA_W-1:0] addr);
        // ram word from the shadow and zero for anything unmapped
        if (addr < DATA_W'(MEM_BYTES)) push_entry(1'b1, addr, '0, shadow[addr[AW+1:2]], 0, 0);
        else push_entry(1'b1, addr, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic build_table();
        add_write(32'h0000_0000, 32'h1234_5678);
        add_write(32'h0000_0010, 32'h5A00_0000 | ($urandom() & 32'h00FF_FFFF));
        add_write(32'h0000_0404, 32'hC300_0000 | ($urandom() & 32'h00FF_FFFF));
        add_write(DATA_W'(MEM_BYTES - 4), $urandom());     // last word
        add_read(32'h0000_0010);
        add_read(32'h0000_0000);
        add_read(32'h0000_0404);
        add_read(DATA_W'(MEM_BYTES - 4));
        add_write(32'h0000_0404, $urandom());               // overwrite
        add_read(32'h0000_0404);
        push_entry(1'b1, I2C_XY_ADDR, 32'h00A0_0140, 32'h00A0_0140, 1'b0, 1'b0);
        push_entry(1'b1, I2C_XY_ADDR, 32'h0011_0022, 32'h0033_0044, 1'b1, 1'b0);
        add_write(SPI_CMD_ADDR, 32'h0000_042A);             // 4 params
        push_entry(1'b0, SPI_PARAM_ADDR, 32'hA5C3_0FF0, '0, 1'b0, 1'b0);
        add_write(SPI_CMD_ADDR, 32'h0000_022C);             // lands mid transfer
        push_entry(1'b0, SPI_PARAM_ADDR, 32'h8143_6699, '0, 1'b0, 1'b1);
        add_read(32'h0000_1000);                            // unmapped
        add_write(DATA_W'(MEM_BYTES + 16), 32'hDEAD_BEEF);  // would alias word 4
        add_read(32'h0000_0010);
    endtask

    // command byte with dc low then params top byte first with dc high
    task automatic push_expected_bits(input logic [31:0] params);
        int i;
        int b;
        for (i = 7; i >= 0; i--) exp_bits.push_back({1'b0, cur_cmd[i]});
        for (b = 0; b < cur_count; b++)
            for (i = 31 - 8 * b; i >= 24 - 8 * b; i--) exp_bits.push_back({1'b1, params[i]});
        n_transfers++;
    endtask

    task automatic apply_entry(input entry_t e);
        int cycles;
        int rises_at_issue;
        @(posedge clk);
        #1;
        rises_at_issue = cs_rises;
        if (e.wait_cs && spi_cs_n_o)
            report_problem("parameter write issued but no SPI transfer is running");
        if (e.rd && e.addr == I2C_XY_ADDR) begin
            i2c_xy_i   = e.wdata;
            i2c_done_i = !e.touch_late;
        end
        read_i    = e.rd;
        write_i   = !e.rd;
        address_i = e.addr;
        wdata_i   = e.wdata;
        if (!e.rd && e.addr == SPI_CMD_ADDR) begin
            cur_cmd   = e.wdata[7:0];
            cur_count = int'(e.wdata[11:8]);
        end
        if (!e.rd && e.addr == SPI_PARAM_ADDR) push_expected_bits(e.wdata);
        cycles = 0;
        @(negedge clk);     // accepting edge still ahead
        @(negedge clk);
        while (!done_o) begin
            if (!busy_o) report_problem("busy_o dropped before done_o");
            cycles++;
            if (e.touch_late && cycles == TOUCH_HOLD) begin
                @(posedge clk);
                #1;
                i2c_xy_i   = e.exp;     // fresh coordinate with the done flag
                i2c_done_i = 1'b1;
            end
            @(negedge clk);
        end
        if (busy_o) report_problem("busy_o high in the done_o cycle");
        if (e.touch_late && cycles <= TOUCH_HOLD)
            report_problem("touch read finished before i2c_done_i was raised");
        if (e.wait_cs && cs_rises == rises_at_issue)
            report_problem("parameter write finished before spi_cs_n_o rose");
        if (e.rd) check_val("rdata_o", rdata_o, e.exp);
        @(posedge clk);
        #1;
        read_i  = 1'b0;
        write_i = 1'b0;
        @(negedge clk);
        if (done_o) report_problem("done_o lasted more than one cycle");
        if (e.rd) check_val("rdata_o (held)", rdata_o, e.exp);
    endtask

    initial begin
        wait (table_ready);
        #(longint'(tbl.size() + 4) * ENTRY_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        table_ready = 1'b0;
        clk        = 1'b0;
        nRst       = 1'b0;
        read_i     = 1'b0;
        write_i    = 1'b0;
        address_i  = '0;
        wdata_i    = '0;
        i2c_xy_i   = '0;
        i2c_done_i = 1'b0;
        cur_cmd    = '0;
        {cur_count, n_transfers, cs_rises, val_errs, spi_errs, proto_errs} = '0;
        void'($urandom(57));
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        nRst = 1'b1;
        @(negedge clk);
        check_val("busy_o", busy_o, 0);
        check_val("done_o", done_o, 0);
        check_val("spi_sclk_o", spi_sclk_o, 0);
        check_val("spi_cs_n_o", spi_cs_n_o, 1);
        cs_base = cs_rises;
        foreach (tbl[i]) apply_entry(tbl[i]);
        repeat (4) @(negedge clk);
        while (!spi_cs_n_o) @(negedge clk);   // let the last transfer drain
        if (exp_bits.size() != 0) report_problem("SPI transfer ended short of its bits");
        if (cs_rises - cs_base != n_transfers)
            report_problem("spi_cs_n_o did not rise once per transfer");
        $display("errors: value %0d, spi %0d, protocol %0d", val_errs, spi_errs, proto_errs);
        if (val_errs + spi_errs + proto_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/mmio_pkg.sv
verilog/mmio_decoder.sv
verilog/wb_master.sv
verilog/wb_sram.sv
verilog/spi_tx.sv
verilog/mmio_subsystem.sv
sim/mmio_tb.sv

/* verilog/mmio_decoder.sv */
`timescale 1ns/1ns

module mmio_decoder import mmio_pkg::*; #(
    parameter int MEM_BYTES = 2048
) (
    input  logic              clk,
    input  logic              nRst,
    // memory handler
    input  logic              read_i,
    input  logic              write_i,
    input  logic [DATA_W-1:0] address_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              busy_o,
    output logic              done_o,
    // touch
    input  logic [DATA_W-1:0] i2c_xy_i,
    input  logic              i2c_done_i,
    // wishbone master side
    input  logic              mem_busy_i,
    input  logic [DATA_W-1:0] mem_rdata_i,
    output logic              mem_read_o,       // one cycle start pulse
    output logic              mem_write_o,      // one cycle start pulse
    output logic [DATA_W-1:0] mem_address_o,
    output logic [DATA_W-1:0] mem_wdata_o,
    // spi side
    input  logic              spi_busy_i,
    output logic [7:0]        spi_command_o,
    output logic [2:0]        spi_count_o,
    output logic [31:0]       spi_params_o,
    output logic              spi_start_o
);

    mmio_state_e state, state_n;

    logic              busy_n, mem_read_n, mem_write_n, spi_start_n;
    logic [DATA_W-1:0] rdata_n, mem_address_n, mem_wdata_n;
    logic [7:0]        spi_command_n;
    logic [2:0]        spi_count_n;
    logic [31:0]       spi_params_n;
    logic              cmd_rd, cmd_wr, is_mem;

    assign cmd_rd = read_i & ~write_i;     // both high is ignored
    assign cmd_wr = write_i & ~read_i;
    assign is_mem = address_i < DATA_W'(MEM_BYTES);
    assign done_o = (state == MMIO_BUSY);

    always_comb begin
        state_n       = state;
        mem_read_n    = 1'b0;   // pulses drop by default
        mem_write_n   = 1'b0;
        spi_start_n   = 1'b0;
        rdata_n       = rdata_o;
        mem_address_n = mem_address_o;
        mem_wdata_n   = mem_wdata_o;
        spi_command_n = spi_command_o;
        spi_count_n   = spi_count_o;
        spi_params_n  = spi_params_o;

        case (state)
            MMIO_IDLE: begin
                if (cmd_rd) begin
                    if (address_i == I2C_XY_ADDR) begin
                        if (i2c_done_i) begin     // else sit here busy
                            state_n = MMIO_BUSY;
                            rdata_n = i2c_xy_i;
                        end
                    end else if (is_mem) begin
                        if (!mem_busy_i) begin
                            state_n       = MMIO_MEMWAIT;
                            mem_read_n    = 1'b1;
                            mem_address_n = address_i;
                        end
                    end else begin
                        state_n = MMIO_BUSY;      // unmapped read gives zero
                        rdata_n = '0;
                    end
                end else if (cmd_wr) begin
                    if (address_i == SPI_CMD_ADDR) begin
                        state_n       = MMIO_BUSY;
                        spi_command_n = wdata_i[7:0];
                        // clamp count to the 4 bytes of the param word
                        spi_count_n   = (wdata_i[11:8] > 4'd4) ? 3'd4 : wdata_i[10:8];
                    end else if (address_i == SPI_PARAM_ADDR) begin
                        if (!spi_busy_i) begin    // previous transfer still shifting
                            state_n      = MMIO_BUSY;
                            spi_params_n = wdata_i;
                            spi_start_n  = 1'b1;
                        end
                    end else if (is_mem) begin
                        if (!mem_busy_i) begin
                            state_n       = MMIO_MEMWAIT;
                            mem_write_n   = 1'b1;
                            mem_address_n = address_i;
                            mem_wdata_n   = wdata_i;
                        end
                    end else begin
                        state_n = MMIO_BUSY;      // unmapped write dropped
                    end
                end
            end
            MMIO_MEMWAIT: begin
                // master raises busy on this edge, pick wait state by pulse
                state_n = mem_read_o ? MMIO_MEMREAD : MMIO_MEMWRITE;
            end
            MMIO_MEMREAD: begin
                if (!mem_busy_i) begin
                    state_n = MMIO_BUSY;
                    rdata_n = mem_rdata_i;
                end
            end
            MMIO_MEMWRITE: begin
                if (!mem_busy_i) state_n = MMIO_BUSY;
            end
            MMIO_BUSY: state_n = MMIO_IDLE;       // done cycle
            default:   state_n = MMIO_IDLE;
        endcase

        // busy while stalled in idle or anywhere on the memory path
        busy_n = (state_n inside {MMIO_MEMWAIT, MMIO_MEMREAD, MMIO_MEMWRITE}) ||
                 (state == MMIO_IDLE && state_n == MMIO_IDLE && (cmd_rd || cmd_wr));
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state       <= MMIO_IDLE;
            busy_o      <= 1'b0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            spi_start_o <= 1'b0;
        end else begin
            state       <= state_n;
            busy_o      <= busy_n;
            mem_read_o  <= mem_read_n;
            mem_write_o <= mem_write_n;
            spi_start_o <= spi_start_n;
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        rdata_o       <= rdata_n;
        mem_address_o <= mem_address_n;
        mem_wdata_o   <= mem_wdata_n;
        spi_command_o <= spi_command_n;
        spi_count_o   <= spi_count_n;
        spi_params_o  <= spi_params_n;
    end

    // handshake: done and busy are exclusive
    a_done_not_busy: assert property (@(posedge clk) disable iff (!nRst)
        !(done_o && busy_o));
    a_one_mem_cmd: assert property (@(posedge clk) disable iff (!nRst)
        !(mem_read_o && mem_write_o));

endmodule

/* verilog/mmio_pkg.sv */
package mmio_pkg;

    localparam int DATA_W = 32;     // data and address bus width

    // mmio register addresses, everything below MEM_BYTES is ram
    localparam logic [DATA_W-1:0] SPI_CMD_ADDR   = 32'd121212;  // cmd byte [7:0], count [11:8]
    localparam logic [DATA_W-1:0] SPI_PARAM_ADDR = 32'd333333;  // param word, write kicks off spi
    localparam logic [DATA_W-1:0] I2C_XY_ADDR    = 32'd923923;  // touch coordinate, read only

    // decoder fsm
    typedef enum logic [2:0] {
        MMIO_IDLE,      // samples read/write from memory handler
        MMIO_BUSY,      // done pulse back to memory handler
        MMIO_MEMWAIT,   // start pulse out, wb master not busy yet
        MMIO_MEMREAD,   // waiting for read data
        MMIO_MEMWRITE   // waiting for write ack
    } mmio_state_e;

    // wishbone master fsm
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_CYCLE,       // cyc/stb up until ack
        WB_DONE         // read data fresh, one cycle
    } wb_state_e;

    // display spi fsm
    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_CMD,        // command byte, dc low
        SPI_PARAM,      // parameter bytes, dc high
        SPI_FINISH      // hold cs low for half a bit
    } spi_state_e;

endpackage

/* verilog/mmio_subsystem.sv */
`timescale 1ns/1ns

module mmio_subsystem import mmio_pkg::*; #(
    parameter int MEM_BYTES   = 2048,
    parameter int WAIT_STATES = 2,
    parameter int SCLK_DIV    = 2
) (
    input  logic              clk,
    input  logic              nRst,
    // memory handler
    input  logic              read_i,
    input  logic              write_i,
    input  logic [DATA_W-1:0] address_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              busy_o,
    output logic              done_o,
    // touch controller
    input  logic [DATA_W-1:0] i2c_xy_i,
    input  logic              i2c_done_i,
    // display
    output logic              spi_sclk_o,
    output logic              spi_mosi_o,
    output logic              spi_cs_n_o,
    output logic              spi_dc_o
);

    // decoder <-> wb master
    logic              mem_read, mem_write, mem_busy;
    logic [DATA_W-1:0] mem_address, mem_wdata, mem_rdata;
    // wb master <-> ram
    logic                wb_cyc, wb_stb, wb_we, wb_ack;
    logic [DATA_W-1:0]   wb_adr, wb_dat_w, wb_dat_r;
    logic [DATA_W/8-1:0] wb_sel;
    // decoder <-> spi
    logic        spi_start, spi_busy;
    logic [7:0]  spi_command;
    logic [2:0]  spi_count;
    logic [31:0] spi_params;

    mmio_decoder #(.MEM_BYTES(MEM_BYTES)) mmio_decoder_i (
        .clk, .nRst, .read_i, .write_i, .address_i, .wdata_i, .rdata_o, .busy_o, .done_o,
        .i2c_xy_i, .i2c_done_i,
        .mem_busy_i(mem_busy), .mem_rdata_i(mem_rdata), .mem_read_o(mem_read),
        .mem_write_o(mem_write), .mem_address_o(mem_address), .mem_wdata_o(mem_wdata),
        .spi_busy_i(spi_busy), .spi_command_o(spi_command), .spi_count_o(spi_count),
        .spi_params_o(spi_params), .spi_start_o(spi_start)
    );

    wb_master wb_master_i (
        .clk, .nRst, .mem_read_i(mem_read), .mem_write_i(mem_write),
        .mem_address_i(mem_address), .mem_wdata_i(mem_wdata),
        .mem_busy_o(mem_busy), .mem_rdata_o(mem_rdata),
        .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
        .wb_dat_o(wb_dat_w), .wb_sel_o(wb_sel), .wb_dat_i(wb_dat_r), .wb_ack_i(wb_ack)
    );

    wb_sram #(.MEM_BYTES(MEM_BYTES), .WAIT_STATES(WAIT_STATES)) wb_sram_i (
        .clk, .nRst, .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we),
        .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel),
        .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack)
    );

    spi_tx #(.SCLK_DIV(SCLK_DIV)) spi_tx_i (
        .clk, .nRst, .start_i(spi_start), .command_i(spi_command), .count_i(spi_count),
        .params_i(spi_params), .busy_o(spi_busy), .sclk_o(spi_sclk_o),
        .mosi_o(spi_mosi_o), .cs_n_o(spi_cs_n_o), .dc_o(spi_dc_o)
    );

endmodule

/* verilog/spi_tx.sv */
`timescale 1ns/1ns

module spi_tx import mmio_pkg::*; #(
    parameter int SCLK_DIV = 2
) (
    input  logic        clk,
    input  logic        nRst,
    input  logic        start_i,        // one cycle
    input  logic [7:0]  command_i,
    input  logic [2:0]  count_i,        // param bytes, 0..4
    input  logic [31:0] params_i,
    output logic        busy_o,
    output logic        sclk_o,
    output logic        mosi_o,
    output logic        cs_n_o,
    output logic        dc_o
);

    localparam int DW = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    spi_state_e  state;
    logic [DW-1:0] div_cnt;
    logic [2:0]  bit_cnt;
    logic [2:0]  bytes_left;
    logic [7:0]  sh;                // current byte, msb out
    logic [31:0] pr;                // remaining params, top byte next
    logic        tick, fall;

    assign tick   = (div_cnt == DW'(SCLK_DIV - 1));
    assign fall   = tick && sclk_o && (state == SPI_CMD || state == SPI_PARAM);
    assign busy_o = (state != SPI_IDLE);
    assign mosi_o = cs_n_o ? 1'b0 : sh[7];     // mode 0, valid before rising edge

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state      <= SPI_IDLE;
            sclk_o     <= 1'b0;
            cs_n_o     <= 1'b1;
            dc_o       <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            bytes_left <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            case (state)
                SPI_IDLE: begin
                    div_cnt <= '0;
                    if (start_i) begin
                        state      <= SPI_CMD;
                        cs_n_o     <= 1'b0;
                        dc_o       <= 1'b0;         // command byte
                        sclk_o     <= 1'b0;
                        bit_cnt    <= '0;
                        bytes_left <= count_i;
                    end
                end
                SPI_CMD, SPI_PARAM: begin
                    if (tick) sclk_o <= ~sclk_o;
                    if (fall) begin
                        bit_cnt <= bit_cnt + 1'b1;  // wraps per byte
                        if (bit_cnt == 3'd7) begin
                            if (bytes_left != '0) begin
                                state      <= SPI_PARAM;
                                dc_o       <= 1'b1;
                                bytes_left <= bytes_left - 1'b1;
                            end else begin
                                state <= SPI_FINISH;
                            end
                        end
                    end
                end
                SPI_FINISH: begin
                    // half bit of hold after last edge, then release cs
                    if (tick) begin
                        cs_n_o <= 1'b1;
                        state  <= SPI_IDLE;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SPI_IDLE && start_i) begin
            sh <= command_i;
            pr <= params_i;
        end else if (fall) begin
            if (bit_cnt == 3'd7) begin
                sh <= pr[31:24];            // params sent from the top byte down
                pr <= {pr[23:0], 8'h00};
            end else begin
                sh <= {sh[6:0], 1'b0};
            end
        end
    end

    // decoder must hold param writes off while shifting
    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRst)
        start_i |-> !busy_o);

endmodule

/* verilog/wb_master.sv */
`timescale 1ns/1ns

module wb_master import mmio_pkg::*; (
    input  logic                clk,
    input  logic                nRst,
    // decoder side
    input  logic                mem_read_i,     // start pulse
    input  logic                mem_write_i,    // start pulse
    input  logic [DATA_W-1:0]   mem_address_i,
    input  logic [DATA_W-1:0]   mem_wdata_i,
    output logic                mem_busy_o,
    output logic [DATA_W-1:0]   mem_rdata_o,
    // wishbone classic
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic [DATA_W-1:0]   wb_adr_o,
    output logic [DATA_W-1:0]   wb_dat_o,
    output logic [DATA_W/8-1:0] wb_sel_o,
    input  logic [DATA_W-1:0]   wb_dat_i,
    input  logic                wb_ack_i
);

    wb_state_e state;
    logic      start;

    assign start = mem_read_i | mem_write_i;

    // cyc/stb held for the whole cycle, dropped on ack edge
    assign wb_cyc_o   = (state == WB_CYCLE);
    assign wb_stb_o   = (state == WB_CYCLE);
    assign mem_busy_o = (state == WB_CYCLE);
    assign wb_sel_o   = '1;                     // full word only

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state   <= WB_IDLE;
            wb_we_o <= 1'b0;
        end else begin
            case (state)
                WB_IDLE, WB_DONE: begin
                    if (start) begin
                        state   <= WB_CYCLE;
                        wb_we_o <= mem_write_i;
                    end else begin
                        state <= WB_IDLE;
                    end
                end
                WB_CYCLE: if (wb_ack_i) state <= WB_DONE;
                default:  state <= WB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state != WB_CYCLE) begin
            wb_adr_o <= mem_address_i;
            wb_dat_o <= mem_wdata_i;
        end
        if (state == WB_CYCLE && wb_ack_i && !wb_we_o)
            mem_rdata_o <= wb_dat_i;            // held until next read
    end

    // slave may only ack inside a cycle we opened
    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!nRst)
        wb_ack_i |-> wb_cyc_o);

endmodule

/* verilog/wb_sram.sv */
`timescale 1ns/1ns

module wb_sram import mmio_pkg::*; #(
    parameter int MEM_BYTES   = 2048,
    parameter int WAIT_STATES = 2
) (
    input  logic                clk,
    input  logic                nRst,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic                wb_we_i,
    input  logic [DATA_W-1:0]   wb_adr_i,
    input  logic [DATA_W-1:0]   wb_dat_i,
    input  logic [DATA_W/8-1:0] wb_sel_i,
    output logic [DATA_W-1:0]   wb_dat_o,
    output logic                wb_ack_o
);

    localparam int WORDS = MEM_BYTES / 4;
    localparam int AW    = $clog2(WORDS);
    localparam int CW    = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [DATA_W-1:0] mem [WORDS];
    logic [CW-1:0]     wait_cnt;
    logic [AW-1:0]     word_idx;
    logic              req, hit;

    assign word_idx = wb_adr_i[AW+1:2];     // byte offset ignored
    assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign hit      = req && (wait_cnt == CW'(WAIT_STATES));   // last wait state

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wb_ack_o <= 1'b0;
            wait_cnt <= '0;
        end else begin
            wb_ack_o <= hit;                // single cycle ack
            if (hit || !(wb_cyc_i && wb_stb_i))
                wait_cnt <= '0;
            else if (req)
                wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // write lands on the ack edge, read data comes out with ack
    always_ff @(posedge clk) begin
        if (hit) begin
            if (wb_we_i) begin
                for (int b = 0; b < DATA_W / 8; b++)
                    if (wb_sel_i[b]) mem[word_idx][8*b +: 8] <= wb_dat_i[8*b +: 8];
            end else begin
                wb_dat_o <= mem[word_idx];
            end
        end
    end

endmodule
